// File: rtl/dmx_pkg.sv
`default_nettype none

package dmx_pkg;

    // widths with a meaning
    typedef logic [2:0] row_idx_t;   // row being scanned
    typedef logic [7:0] col_t;       // 1 = led on
    typedef logic [7:0] row_drv_t;   // active low row lines
    typedef logic [3:0] frame_id_t;
    typedef logic [7:0] div_t;       // row lasts div+1 clocks

    typedef logic [1:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // host register map
    localparam reg_addr_t ADDR_CTRL  = 2'd0;  // bit0 enable, bit1 temp
    localparam reg_addr_t ADDR_FRAME = 2'd1;
    localparam reg_addr_t ADDR_DIV   = 2'd2;

    typedef enum logic
    {
        SCAN_IDLE,
        SCAN_RUN
    } scan_state_t;

endpackage

`default_nettype wire

// File: rtl/dmx_cfg_regs.sv
`default_nettype none

module dmx_cfg_regs
#(
    parameter dmx_pkg::div_t DIV_RESET = 8'd3
)
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 wr_en,
    input  dmx_pkg::reg_addr_t  addr,
    input  dmx_pkg::reg_data_t  wdata,
    output dmx_pkg::reg_data_t  rdata,
    output logic                enable,
    output logic                temp,
    output dmx_pkg::frame_id_t  frame,
    output dmx_pkg::div_t       divider
);

    // control register
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            enable <= 1'b0;
            temp   <= 1'b0;
        end
        else if (wr_en && addr == dmx_pkg::ADDR_CTRL)
        begin
            enable <= wdata[0];
            temp   <= wdata[1];
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            frame <= '0;
        else if (wr_en && addr == dmx_pkg::ADDR_FRAME)
            frame <= wdata[3:0]; // upper bits dropped
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            divider <= DIV_RESET;
        else if (wr_en && addr == dmx_pkg::ADDR_DIV)
            divider <= wdata;
    end

    // read-back with unused bits zero
    always_comb
    begin
        case (addr)
            dmx_pkg::ADDR_CTRL:
                rdata = dmx_pkg::reg_data_t'({temp, enable});
            dmx_pkg::ADDR_FRAME:
                rdata = dmx_pkg::reg_data_t'(frame);
            dmx_pkg::ADDR_DIV:
                rdata = divider;
            default:
                rdata = '0;  // address 3 unmapped
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/dmx_glyph_rom.sv
`default_nettype none

module dmx_glyph_rom
(
    input  dmx_pkg::frame_id_t  frame,
    input  dmx_pkg::row_idx_t   row_idx,
    input  wire                 temp,
    output dmx_pkg::col_t       green,
    output dmx_pkg::col_t       red
);

    // green table
    always_comb
    begin
        green = 8'b0000_0000;
        case (frame)
            4'd0:  // smallest blob
                case (row_idx)
                    3'd2, 3'd5: green = 8'b0001_1000;
                    3'd3, 3'd4: green = 8'b0011_1100;
                    default:    green = 8'b0000_0000;
                endcase
            4'd1:
                case (row_idx)
                    3'd2, 3'd5: green = 8'b0011_1000;
                    3'd3, 3'd4: green = 8'b0111_1100;
                    default:    green = 8'b0000_0000;
                endcase
            4'd2:
                case (row_idx)
                    3'd2, 3'd5: green = 8'b0011_1100;
                    3'd3, 3'd4: green = 8'b0111_1110;
                    default:    green = 8'b0000_0000;
                endcase
            4'd3:
                case (row_idx)
                    3'd1, 3'd6: green = 8'b0011_1100;
                    3'd2, 3'd3,
                    3'd4, 3'd5: green = 8'b0111_1110;
                    default:    green = 8'b0000_0000;
                endcase
            4'd4:  // blob fills the matrix
                case (row_idx)
                    3'd0, 3'd7: green = 8'b0011_1100;
                    3'd1, 3'd6: green = 8'b0111_1110;
                    default:    green = 8'b1111_1111;
                endcase
            4'd5:
                green = 8'b1111_1111;  // solid
            4'd6:
                case (row_idx)
                    3'd0: green = 8'b1100_0011;
                    3'd1: green = 8'b1110_0011;
                    3'd2: green = 8'b1111_0001;
                    3'd3: green = 8'b1110_0011;
                    3'd4: green = 8'b1100_0111;
                    3'd5: green = 8'b1110_0111;
                    3'd6: green = 8'b1111_0111;
                    3'd7: green = 8'b1111_1011;
                    default: green = 8'b0000_0000;
                endcase
            4'd7:
                case (row_idx)
                    3'd1: green = 8'b0000_0001;
                    3'd2: green = 8'b1000_0001;
                    3'd3: green = 8'b1100_0011;
                    3'd4: green = 8'b1000_0011;
                    3'd5: green = 8'b1100_0111;
                    3'd6: green = 8'b1110_0111;
                    3'd7: green = 8'b1111_0011;
                    default: green = 8'b0000_0000;
                endcase
            4'd9:
                case (row_idx)
                    3'd2: green = 8'b0110_0000;
                    3'd3: green = 8'b1111_1100;
                    3'd4: green = 8'b0011_1111;
                    3'd5: green = 8'b0011_1110;
                    3'd6: green = 8'b0001_1100;
                    default: green = 8'b0000_0000;
                endcase
            4'd10:
                case (row_idx)
                    3'd2:       green = 8'b0001_1000;
                    3'd3:       green = 8'b0011_1100;
                    3'd4, 3'd5: green = 8'b0111_1110;
                    3'd6:       green = 8'b0010_0100;
                    default:    green = 8'b0000_0000;
                endcase
            default:
                green = 8'b0000_0000;  // 8, 11..15 no green
        endcase
    end

    // red follows green except the red-only frames
    always_comb
    begin
        red = 8'b0000_0000;
        case (frame)
            4'd8:  // warning face independent of temp
                case (row_idx)
                    3'd1: red = 8'b0011_1000;
                    3'd2: red = 8'b0100_0100;
                    3'd3: red = 8'b0101_1010;
                    3'd4: red = 8'b0100_1010;
                    3'd5: red = 8'b0011_0010;
                    3'd6: red = 8'b1100_0100;
                    3'd7: red = 8'b0011_1000;
                    default: red = 8'b0000_0000;
                endcase
            4'd11:
                case (row_idx)
                    3'd0: red = 8'b1110_0000;
                    3'd1: red = 8'b0110_0000;
                    3'd2: red = 8'b1110_0000;
                    3'd3: red = 8'b0011_0000;
                    3'd4: red = 8'b0011_0001;
                    3'd5: red = 8'b0011_0011;
                    3'd6: red = 8'b0011_1110;
                    3'd7: red = 8'b0001_1100;
                    default: red = 8'b0000_0000;
                endcase
            4'd6, 4'd7, 4'd9:
                red = green;  // always amber
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5:
                red = temp ? green : 8'b0000_0000;  // gauge goes amber on alarm
            default:
                red = 8'b0000_0000;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/dmx_row_scan.sv
`default_nettype none

module dmx_row_scan
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 enable,
    input  dmx_pkg::div_t       divider,
    input  dmx_pkg::frame_id_t  frame,
    input  dmx_pkg::col_t       green,
    input  dmx_pkg::col_t       red,
    output dmx_pkg::frame_id_t  lut_frame,
    output dmx_pkg::row_idx_t   row_idx,
    output dmx_pkg::row_drv_t   row,
    output dmx_pkg::col_t       colg,
    output dmx_pkg::col_t       colr,
    output logic                frame_sync
);

    dmx_pkg::scan_state_t state;
    dmx_pkg::div_t        presc;
    dmx_pkg::div_t        div_q;    // divider of the current row
    logic                 row_end;
    logic                 run;

    assign run     = (state == dmx_pkg::SCAN_RUN) && enable;
    assign row_end = (presc == div_q);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            state <= dmx_pkg::SCAN_IDLE;
        else if (!enable)
            state <= dmx_pkg::SCAN_IDLE;
        else
            state <= dmx_pkg::SCAN_RUN;
    end

    // prescaler, row counter and frame latch
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            presc     <= '0;
            div_q     <= '0;
            row_idx   <= '0;
            lut_frame <= '0;
        end
        else if (state == dmx_pkg::SCAN_IDLE)
        begin
            if (enable)
            begin
                // start of scanning
                presc     <= '0;
                div_q     <= divider;
                row_idx   <= '0;
                lut_frame <= frame;
            end
        end
        else if (enable)
        begin
            if (row_end)
            begin
                presc   <= '0;
                div_q   <= divider;  // new divider at row boundary
                row_idx <= row_idx + 3'd1;
                if (row_idx == 3'd7)
                    lut_frame <= frame;  // only on wrap to row 0
            end
            else
            begin
                presc <= presc + 8'd1;
            end
        end
    end

    // registered matrix drive that blanks while idle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row        <= '1;
            colg       <= '0;
            colr       <= '0;
            frame_sync <= 1'b0;
        end
        else if (run)
        begin
            row        <= ~(dmx_pkg::row_drv_t'(1) << row_idx);
            colg       <= green;
            colr       <= red;
            frame_sync <= (presc == '0) && (row_idx == '0);  // first cycle of row 0
        end
        else
        begin
            row        <= '1;
            colg       <= '0;
            colr       <= '0;
            frame_sync <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dmx_top.sv
`default_nettype none

module dmx_top
#(
    parameter dmx_pkg::div_t DIV_RESET = 8'd3
)
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 wr_en,
    input  dmx_pkg::reg_addr_t  addr,
    input  dmx_pkg::reg_data_t  wdata,
    output dmx_pkg::reg_data_t  rdata,
    output dmx_pkg::row_drv_t   row,
    output dmx_pkg::col_t       colg,
    output dmx_pkg::col_t       colr,
    output logic                frame_sync
);

    logic                enable;
    logic                temp;
    dmx_pkg::frame_id_t  frame;
    dmx_pkg::div_t       divider;
    dmx_pkg::frame_id_t  lut_frame;
    dmx_pkg::row_idx_t   row_idx;
    dmx_pkg::col_t       green;
    dmx_pkg::col_t       red;

    dmx_cfg_regs #(
        .DIV_RESET (DIV_RESET)
    ) cfg_regs_i (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .addr    (addr),
        .wdata   (wdata),
        .rdata   (rdata),
        .enable  (enable),
        .temp    (temp),
        .frame   (frame),
        .divider (divider)
    );

    dmx_row_scan row_scan_i (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .divider    (divider),
        .frame      (frame),
        .green      (green),
        .red        (red),
        .lut_frame  (lut_frame),
        .row_idx    (row_idx),
        .row        (row),
        .colg       (colg),
        .colr       (colr),
        .frame_sync (frame_sync)
    );

    // temp bypasses the frame latch
    dmx_glyph_rom glyph_rom_i (
        .frame   (lut_frame),
        .row_idx (row_idx),
        .temp    (temp),
        .green   (green),
        .red     (red)
    );

endmodule

`default_nettype wire

// File: sim/tb_dmx_top.sv
`default_nettype none

module tb_dmx_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [7:0] DIV_RESET = 8'd3;
    localparam int         SYNC_TIMEOUT = 8 * 256 + 20;

    logic       clk;
    logic       rst;
    logic       wr_en;
    logic [1:0] addr;
    logic [7:0] wdata;
    logic [7:0] rdata;
    logic [7:0] row;
    logic [7:0] colg;
    logic [7:0] colr;
    logic       frame_sync;

    // host-side copies of the registers
    logic       en_sh;
    logic       temp_sh;
    logic [3:0] frame_sh;
    int         div_sh;

    logic [3:0] cur_frame;   // frame currently on the matrix
    logic [7:0] prev_row;
    int         hold;        // samples the previous row value lasted
    logic       check_col;
    logic [7:0] red_seen [2][8];

    dmx_top #(
        .DIV_RESET (DIV_RESET)
    ) dmx_top_i (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .row        (row),
        .colg       (colg),
        .colr       (colr),
        .frame_sync (frame_sync)
    );

    always #2 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic timed_out(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic int row_pos(input logic [7:0] r);
        int pos;
        pos = 0;
        for (int i = 0; i < 8; i++)
            if (!r[i])
                pos = i;
        return pos;
    endfunction

    // colour policy of the glyph table without the exact pictures
    function automatic logic col_rule_ok(input logic [3:0] f, input logic t,
                                         input logic [7:0] g, input logic [7:0] r);
        logic gauge_red_ok;
        gauge_red_ok = t ? (r == g) : (r == 8'h00);
        case (f)
            4'd5:                   return (g == 8'hff) && gauge_red_ok;
            4'd0, 4'd1, 4'd2,
            4'd3, 4'd4:             return gauge_red_ok;
            4'd6, 4'd7, 4'd9:       return r == g;
            4'd10:                  return r == 8'h00;
            4'd8, 4'd11:            return g == 8'h00;
            default:                return (g == 8'h00) && (r == 8'h00);
        endcase
    endfunction

    always @(posedge clk)
    begin
        if (rst)
        begin
            prev_row  <= 8'hff;
            hold      <= 0;
            cur_frame <= 4'd0;
        end
        else
        begin
            prev_row <= row;
            hold     <= (row == prev_row) ? hold + 1 : 1;
            if (frame_sync)
                cur_frame <= frame_sh;
            if (check_col && row != 8'hff)
                red_seen[temp_sh][row_pos(row)] <= colr;
        end
    end

    row_single_zero: assert property (@(posedge clk) disable iff (rst)
        (row != 8'hff) |-> ($countones(~row) == 1))
        else fail_now("row drive has more than one active line");

    row_step_and_period: assert property (@(posedge clk) disable iff (rst)
        (row != 8'hff && prev_row != 8'hff && row != prev_row)
            |-> (row == {prev_row[6:0], prev_row[7]} && hold == div_sh + 1))
        else fail_now("row did not advance by one after divider+1 cycles");

    sync_only_on_row0: assert property (@(posedge clk) disable iff (rst)
        frame_sync |-> (row == 8'hfe && prev_row != 8'hfe))
        else fail_now("frame_sync outside the first cycle of row 0");

    row0_has_sync: assert property (@(posedge clk) disable iff (rst)
        (row == 8'hfe && prev_row != 8'hfe) |-> frame_sync)
        else fail_now("row 0 started without frame_sync");

    restart_at_row0: assert property (@(posedge clk) disable iff (rst)
        (prev_row == 8'hff && row != 8'hff) |-> (row == 8'hfe))
        else fail_now("scan did not restart at row 0");

    blank_when_off: assert property (@(posedge clk) disable iff (rst)
        !en_sh |=> (row == 8'hff && colg == 8'h00 && colr == 8'h00 && !frame_sync))
        else fail_now("matrix not blanked while disabled");

    colour_rule: assert property (@(posedge clk) disable iff (rst)
        (check_col && row != 8'hff)
            |-> col_rule_ok(frame_sync ? frame_sh : cur_frame, temp_sh, colg, colr))
        else fail_now("column pattern breaks the frame colour rule");

    task automatic host_write(input logic [1:0] a, input logic [7:0] d);
        wr_en = 1'b1;
        addr  = a;
        wdata = d;
        @(posedge clk);
        #1;
        wr_en = 1'b0;
        case (a)
            2'd0:
            begin
                en_sh   = d[0];
                temp_sh = d[1];
            end
            2'd1:    frame_sh = d[3:0];
            2'd2:    div_sh = d;
            default: ;
        endcase
    endtask

    task automatic host_read(input logic [1:0] a, input logic [7:0] expected);
        addr = a;
        #1;
        if (rdata !== expected)
            fail_now($sformatf("read addr %0d gave %h, expected %h", a, rdata, expected));
        @(posedge clk);
        #1;
    endtask

    task automatic wait_frame_sync();
        int n;
        n = 0;
        do
        begin
            @(posedge clk);
            #1;
            n++;
            if (n > SYNC_TIMEOUT)
                timed_out("frame_sync");
        end
        while (!frame_sync);
    endtask

    task automatic wait_cycles(input int n);
        int i;
        i = 0;
        while (i < n)
        begin
            @(posedge clk);
            #1;
            i++;
        end
    endtask

    // one whole frame with the given settings and a disable after it
    task automatic run_frame(input logic [3:0] f, input logic t, input logic [7:0] d);
        host_write(2'd2, d);
        host_write(2'd1, {4'd0, f});
        host_write(2'd0, {6'd0, t, 1'b1});
        check_col = 1'b1;
        wait_frame_sync();
        wait_frame_sync();
        check_col = 1'b0;
        host_write(2'd0, 8'h00);
        wait_cycles(3);
    endtask

    task automatic check_red_only(input logic [3:0] f, input logic [7:0] d);
        logic any_red;
        run_frame(f, 1'b0, d);
        run_frame(f, 1'b1, d);
        any_red = 1'b0;
        for (int i = 0; i < 8; i++)
        begin
            if (red_seen[0][i] != red_seen[1][i])
                fail_now($sformatf("frame %0d red differs with temp in row %0d", f, i));
            if (red_seen[0][i] != 8'h00)
                any_red = 1'b1;
        end
        if (!any_red)
            fail_now($sformatf("frame %0d shows no red at all", f));
    endtask

    initial
    begin
        logic [7:0] d;
        logic [3:0] f;
        clk       = 1'b0;
        rst       = 1'b1;
        wr_en     = 1'b0;
        addr      = 2'd0;
        wdata     = 8'h00;
        en_sh     = 1'b0;
        temp_sh   = 1'b0;
        frame_sh  = 4'd0;
        div_sh    = DIV_RESET;
        check_col = 1'b0;
        void'($urandom(48986));
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        if (row !== 8'hff || colg !== 8'h00 || colr !== 8'h00 || frame_sync !== 1'b0)
            fail_now("outputs not idle after reset");
        host_read(2'd0, 8'h00);
        host_read(2'd1, 8'h00);
        host_read(2'd2, DIV_RESET);

        host_write(2'd1, 8'hf7);
        host_read(2'd1, 8'h07);
        host_write(2'd2, 8'ha5);
        host_read(2'd2, 8'ha5);
        host_write(2'd0, 8'hfe);   // temp only and still disabled
        host_read(2'd0, 8'h02);
        host_read(2'd3, 8'h00);
        host_write(2'd0, 8'h00);

        // scan order and period for two dividers
        repeat (2)
        begin
            d = 8'($urandom_range(0, 6));
            f = 4'($urandom_range(0, 15));
            run_frame(f, 1'b0, d);
        end

        f = 4'($urandom_range(0, 15));
        run_frame(f, 1'b0, 8'd1);
        run_frame(f, 1'b1, 8'd1);
        run_frame(4'd5, 1'b1, 8'd0);
        run_frame(4'd10, 1'b0, 8'd0);
        run_frame(4'd12, 1'b1, 8'd0);
        run_frame(4'd7, 1'b0, 8'd0);
        check_red_only(4'd8, 8'd1);
        check_red_only(4'd11, 8'd0);

        // frame written mid-frame shows from the next sync
        host_write(2'd2, 8'd2);
        host_write(2'd1, 8'd5);
        host_write(2'd0, 8'h01);
        check_col = 1'b1;
        wait_frame_sync();
        wait_cycles(7);
        host_write(2'd1, 8'd13);
        wait_frame_sync();
        wait_frame_sync();

        // blanking and restart
        check_col = 1'b0;
        host_write(2'd0, 8'h00);
        wait_cycles(20);
        host_write(2'd0, 8'h01);
        wait_frame_sync();
        wait_cycles(5);
        host_write(2'd0, 8'h00);
        wait_cycles(5);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
rtl/dmx_pkg.sv
rtl/dmx_cfg_regs.sv
rtl/dmx_glyph_rom.sv
rtl/dmx_row_scan.sv
rtl/dmx_top.sv
sim/tb_dmx_top.sv

// File: Bender.yml
package:
  name: dmx

sources:
  - files:
      - rtl/dmx_pkg.sv
      - rtl/dmx_cfg_regs.sv
      - rtl/dmx_glyph_rom.sv
      - rtl/dmx_row_scan.sv
      - rtl/dmx_top.sv
  - target: simulation
    files:
      - sim/tb_dmx_top.sv
